// File: Makefile
# Verilator flow for the execute stage

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing -f files.f --top-module exec_top
	verilator --lint-only --timing -f files.f --top-module tb_exec_top

sim:
	verilator --binary --timing -Wno-fatal -f files.f --top-module tb_exec_top \
		-Mdir obj_dir -o tb_exec_top
	./obj_dir/tb_exec_top | tee sim.log
	grep -q "^PASS: all tests$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: alu_core.sv
module alu_core (
    input  logic                        clk,
    input  logic                        rst_n,
    exec_if.observer                    q,
    output logic [alu_pkg::DATA_W-1:0]  result,
    output alu_pkg::alu_flags_t         flags,
    output logic                        flags_valid,
    output logic                        valid
);
    import alu_pkg::*;

    alu_flags_t         flag_q;
    alu_flags_t         flags_d;
    logic [DATA_W-1:0]  res_d;
    logic               wr_flags;
    logic               scalar;
    logic [31:0]        a32;
    logic [31:0]        b32;
    logic [31:0]        r32;
    logic [4:0]         shamt;
    logic [32:0]        add_ext;
    logic [4:0]         nib_sum;
    logic [32:0]        sal_ext;
    logic signed [32:0] sar_ext;
    logic [4:0]         bsf_idx;
    logic               daa_lo;
    logic               daa_hi;
    logic [7:0]         daa_r;

    // signed word to signed byte with saturation
    function automatic logic [7:0] sat_byte(input logic [15:0] w);
        if ($signed(w) > 16'sd127) begin
            sat_byte = 8'h7f;
        end else if ($signed(w) < -16'sd128) begin
            sat_byte = 8'h80;
        end else begin
            sat_byte = w[7:0];
        end
    endfunction

    assign a32     = q.head_a[31:0];
    assign b32     = q.head_b[31:0];
    assign shamt   = b32[4:0];
    assign add_ext = {1'b0, a32} + {1'b0, b32};
    assign nib_sum = {1'b0, a32[3:0]} + {1'b0, b32[3:0]};

    // extra bit catches the last bit shifted out
    assign sal_ext = {1'b0, a32} << shamt;
    assign sar_ext = $signed({a32, 1'b0}) >>> shamt;

    // daa uses af/cf of the previous flag-writing op
    assign daa_lo = (a32[3:0] > 4'd9) || flag_q.af;
    assign daa_hi = (a32[7:0] > 8'h99) || flag_q.cf;
    assign daa_r  = a32[7:0] + (daa_lo ? 8'h06 : 8'h00) + (daa_hi ? 8'h60 : 8'h00);

    // lowest set bit wins
    always_comb begin
        bsf_idx = 5'd0;
        for (int i = 31; i >= 0; i--) begin
            if (a32[i]) begin
                bsf_idx = 5'(i);
            end
        end
    end

    //////////////////////////////
    // result and flag select
    //////////////////////////////

    always_comb begin
        r32      = 32'd0;
        res_d    = '0;
        flags_d  = '0;
        wr_flags = 1'b1;
        scalar   = 1'b1;
        case (q.head_op)
            OP_ADD: begin
                r32        = add_ext[31:0];
                flags_d.cf = add_ext[32];
                flags_d.af = nib_sum[4];
                flags_d.of = (a32[31] == b32[31]) && (add_ext[31] != a32[31]);
            end
            OP_AND:  r32 = a32 & b32;
            OP_OR:   r32 = a32 | b32;
            OP_NOT:  r32 = ~a32;
            OP_MOVB: r32 = b32;
            OP_SAL: begin
                r32        = sal_ext[31:0];
                flags_d.cf = sal_ext[32];
                flags_d.of = sal_ext[31] ^ sal_ext[32];
                wr_flags   = (shamt != 5'd0);
            end
            OP_SAR: begin
                r32        = sar_ext[32:1];
                flags_d.cf = sar_ext[0];
                wr_flags   = (shamt != 5'd0);
            end
            OP_BSF: r32 = {27'd0, bsf_idx};
            OP_DAA: begin
                r32        = {24'd0, daa_r};
                flags_d.af = daa_lo;
                flags_d.cf = daa_hi;
            end
            // packed ops leave the flags alone
            OP_PADDW: begin
                scalar   = 1'b0;
                wr_flags = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    res_d[16*i +: 16] = q.head_a[16*i +: 16] + q.head_b[16*i +: 16];
                end
            end
            OP_PADDD: begin
                scalar   = 1'b0;
                wr_flags = 1'b0;
                for (int i = 0; i < 2; i++) begin
                    res_d[32*i +: 32] = q.head_a[32*i +: 32] + q.head_b[32*i +: 32];
                end
            end
            OP_PACKSSWB: begin
                scalar   = 1'b0;
                wr_flags = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    res_d[8*i +: 8]      = sat_byte(q.head_a[16*i +: 16]);
                    res_d[32 + 8*i +: 8] = sat_byte(q.head_b[16*i +: 16]);
                end
            end
            OP_PUNPCKHBW: begin
                scalar   = 1'b0;
                wr_flags = 1'b0;
                for (int i = 0; i < 4; i++) begin
                    res_d[16*i +: 8]     = q.head_a[32 + 8*i +: 8];
                    res_d[16*i + 8 +: 8] = q.head_b[32 + 8*i +: 8];
                end
            end
            default: begin
                scalar   = 1'b0;
                wr_flags = 1'b0;
            end
        endcase

        // zf/sf/pf from the 32-bit result, bsf only reports a zero source
        if (q.head_op == OP_BSF) begin
            flags_d.zf = (a32 == 32'd0);
        end else begin
            flags_d.zf = (r32 == 32'd0);
            flags_d.sf = r32[31];
            flags_d.pf = ~^r32[7:0];
        end
        if (scalar) begin
            res_d = {32'd0, r32};
        end
    end

    //////////////////////////////
    // registers
    //////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            flag_q      <= '0;
            valid       <= 1'b0;
            flags_valid <= 1'b0;
        end else begin
            valid       <= q.pop;
            flags_valid <= q.pop && wr_flags;
            if (q.pop && wr_flags) begin
                flag_q <= flags_d;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (q.pop) begin
            result <= res_d;
            flags  <= wr_flags ? flags_d : flag_q;
        end
    end

endmodule

// File: alu_pkg.sv
package alu_pkg;

    // operand and result width, fixed by the MMX register size
    localparam int DATA_W = 64;

    //////////////////////////////
    // opcodes
    //////////////////////////////

    typedef enum logic [3:0] {
        OP_ADD, OP_AND, OP_OR, OP_NOT, OP_MOVB,
        OP_SAL, OP_SAR, OP_BSF, OP_DAA,
        OP_PADDW, OP_PADDD, OP_PACKSSWB, OP_PUNPCKHBW
    } alu_op_e;

    // arithmetic flags, same subset as EFLAGS without df
    typedef struct packed {
        logic cf;
        logic pf;
        logic af;
        logic zf;
        logic sf;
        logic of;
    } alu_flags_t;

    //////////////////////////////
    // issue controller states
    //////////////////////////////

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ISSUE,
        ST_STALL
    } exec_state_e;

endpackage

// File: credit_counter.sv
module credit_counter #(
    parameter int OUT_CREDITS = 2
) (
    input  logic clk,
    input  logic rst_n,
    input  logic take,
    input  logic give,
    output logic has_credit
);

    localparam int CNT_W = $clog2(OUT_CREDITS + 1);

    logic [CNT_W-1:0] count;

    assign has_credit = (count != '0);

    // take and give together leave the count alone
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            count <= CNT_W'(OUT_CREDITS);
        end else begin
            case ({take, give})
                2'b10:   count <= count - 1'b1;
                2'b01:   count <= count + 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_underflow: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> count != '0)
        else $error("credit_counter: take with no credit");

    // receiver returns only what it was given
    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        give && !take |-> count < CNT_W'(OUT_CREDITS))
        else $error("credit_counter: credit returned beyond limit");

endmodule

// File: exec_ctrl.sv
module exec_ctrl (
    input  logic clk,
    input  logic rst_n,
    input  logic has_credit,
    exec_if.ctrl q,
    output logic issue
);
    import alu_pkg::*;

    exec_state_e state_q;
    exec_state_e state_d;

    //////////////////////////////
    // issue decision
    //////////////////////////////

    always_comb begin
        if (q.empty) begin
            state_d = ST_IDLE;
        end else if (has_credit) begin
            state_d = ST_ISSUE;
        end else begin
            // head waits for the receiver
            state_d = ST_STALL;
        end
    end

    assign issue = (state_d == ST_ISSUE);
    assign q.pop = issue;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= ST_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // a stalled head can't drain by itself, it stays until it issues
    a_stall_hold: assert property (@(posedge clk) disable iff (!rst_n)
        state_q == ST_STALL |-> !q.empty)
        else $error("exec_ctrl: stalled head left the queue without issue");

endmodule

// File: exec_if.sv
interface exec_if;
    import alu_pkg::*;

    // queue head, valid while empty is low
    alu_op_e           head_op;
    logic [DATA_W-1:0] head_a;
    logic [DATA_W-1:0] head_b;
    logic              empty;

    // issue strobe, one entry leaves the queue
    logic              pop;

    modport queue (output head_op, head_a, head_b, empty, input pop);

    modport ctrl (input empty, output pop);

    modport observer (input head_op, head_a, head_b, pop);

endinterface

// File: exec_top.sv
module exec_top #(
    parameter int QUEUE_DEPTH = 4,
    parameter int OUT_CREDITS = 2
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       in_valid,
    input  alu_pkg::alu_op_e           in_op,
    input  logic [alu_pkg::DATA_W-1:0] in_a,
    input  logic [alu_pkg::DATA_W-1:0] in_b,
    input  logic                       out_credit,
    output logic                       in_credit,
    output logic                       out_valid,
    output logic [alu_pkg::DATA_W-1:0] out_result,
    output alu_pkg::alu_flags_t        out_flags,
    output logic                       out_flags_valid
);

    logic issue;
    logic has_credit;

    exec_if u_if ();

    // input side, credits go back to the sender on each pop
    op_queue #(
        .QUEUE_DEPTH (QUEUE_DEPTH)
    ) u_queue (
        .clk        (clk),
        .rst_n      (rst_n),
        .push       (in_valid),
        .push_op    (in_op),
        .push_a     (in_a),
        .push_b     (in_b),
        .credit_ret (in_credit),
        .q          (u_if.queue)
    );

    // output side credits
    credit_counter #(
        .OUT_CREDITS (OUT_CREDITS)
    ) u_credit (
        .clk        (clk),
        .rst_n      (rst_n),
        .take       (issue),
        .give       (out_credit),
        .has_credit (has_credit)
    );

    exec_ctrl u_ctrl (
        .clk        (clk),
        .rst_n      (rst_n),
        .has_credit (has_credit),
        .q          (u_if.ctrl),
        .issue      (issue)
    );

    alu_core u_alu (
        .clk         (clk),
        .rst_n       (rst_n),
        .q           (u_if.observer),
        .result      (out_result),
        .flags       (out_flags),
        .flags_valid (out_flags_valid),
        .valid       (out_valid)
    );

endmodule

// File: files.f
+incdir+.
alu_pkg.sv
exec_if.sv
op_queue.sv
credit_counter.sv
exec_ctrl.sv
alu_core.sv
exec_top.sv
tb_exec_top.sv

// File: op_queue.sv
module op_queue #(
    parameter int QUEUE_DEPTH = 4
) (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       push,
    input  alu_pkg::alu_op_e           push_op,
    input  logic [alu_pkg::DATA_W-1:0] push_a,
    input  logic [alu_pkg::DATA_W-1:0] push_b,
    output logic                       credit_ret,
    exec_if.queue                      q
);
    import alu_pkg::*;

    localparam int PTR_W = (QUEUE_DEPTH > 1) ? $clog2(QUEUE_DEPTH) : 1;
    localparam int CNT_W = $clog2(QUEUE_DEPTH + 1);

    alu_op_e           op_mem [QUEUE_DEPTH];
    logic [DATA_W-1:0] a_mem  [QUEUE_DEPTH];
    logic [DATA_W-1:0] b_mem  [QUEUE_DEPTH];
    logic [PTR_W-1:0]  wr_ptr;
    logic [PTR_W-1:0]  rd_ptr;
    logic [CNT_W-1:0]  count;
    logic              full;

    // wrap at depth, depth need not be a power of two
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        ptr_inc = (p == PTR_W'(QUEUE_DEPTH - 1)) ? '0 : p + 1'b1;
    endfunction

    assign full      = (count == CNT_W'(QUEUE_DEPTH));
    assign q.empty   = (count == '0);
    assign q.head_op = op_mem[rd_ptr];
    assign q.head_a  = a_mem[rd_ptr];
    assign q.head_b  = b_mem[rd_ptr];

    // entry storage
    always_ff @(posedge clk) begin
        if (push) begin
            op_mem[wr_ptr] <= push_op;
            a_mem[wr_ptr]  <= push_a;
            b_mem[wr_ptr]  <= push_b;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            credit_ret <= 1'b0;
        end else begin
            // one credit back to the sender per pop, a cycle later
            credit_ret <= q.pop;
            if (push) begin
                wr_ptr <= ptr_inc(wr_ptr);
            end
            if (q.pop) begin
                rd_ptr <= ptr_inc(rd_ptr);
            end
            case ({push, q.pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // sender must never spend a credit it does not hold
    a_no_overrun: assert property (@(posedge clk) disable iff (!rst_n) push |-> !full)
        else $error("op_queue: push while full");

endmodule

// File: tb_alu_model.svh
`ifndef TB_ALU_MODEL_SVH
`define TB_ALU_MODEL_SVH

// even number of ones in the byte
function automatic logic parity_even(input logic [7:0] v);
    int ones;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
        if (v[i]) begin
            ones++;
        end
    end
    return (ones % 2) == 0;
endfunction

// signed word clamped to the signed byte range
function automatic logic [7:0] sat_s8(input logic [15:0] w);
    int v;
    v = int'($signed(w));
    if (v > 127) begin
        return 8'h7f;
    end
    if (v < -128) begin
        return 8'h80;
    end
    return v[7:0];
endfunction

// result, flags as shown on the output, and whether the op writes flags
function automatic void model_op(input alu_op_e op, input logic [63:0] a,
                                 input logic [63:0] b, input alu_flags_t fin,
                                 output logic [63:0] res, output alu_flags_t fout,
                                 output logic wr);
    logic [31:0] r;
    logic [32:0] sum;
    int          n;
    int          idx;
    logic        lo;
    logic        hi;
    logic        lane_op;
    r       = a[31:0];
    res     = '0;
    fout    = '0;
    wr      = 1'b1;
    lane_op = 1'b0;
    n       = int'(b[4:0]);
    case (op)
        OP_ADD: begin
            sum     = {1'b0, a[31:0]} + {1'b0, b[31:0]};
            r       = sum[31:0];
            fout.cf = sum[32];
            fout.af = ({1'b0, a[3:0]} + {1'b0, b[3:0]}) > 5'd15;
            fout.of = (a[31] == b[31]) && (r[31] != a[31]);
        end
        OP_AND:  r = a[31:0] & b[31:0];
        OP_OR:   r = a[31:0] | b[31:0];
        OP_NOT:  r = ~a[31:0];
        OP_MOVB: r = b[31:0];
        OP_SAL, OP_SAR: begin
            // one bit per step, cf keeps the bit that just fell out
            for (int i = 0; i < n; i++) begin
                if (op == OP_SAL) begin
                    fout.cf = r[31];
                    r = {r[30:0], 1'b0};
                end else begin
                    fout.cf = r[0];
                    r = {r[31], r[31:1]};
                end
            end
            fout.of = (op == OP_SAL) ? (r[31] ^ fout.cf) : 1'b0;
            wr = (n != 0);
        end
        OP_BSF: begin
            idx = -1;
            for (int i = 0; i < 32; i++) begin
                if (a[i] && idx < 0) begin
                    idx = i;
                end
            end
            r = (idx < 0) ? 32'd0 : 32'(idx);
        end
        OP_DAA: begin
            lo = (a[3:0] > 4'd9) || fin.af;
            hi = (a[7:0] > 8'h99) || fin.cf;
            r  = {24'd0, a[7:0]};
            if (lo) begin
                r[7:0] = r[7:0] + 8'h06;
            end
            if (hi) begin
                r[7:0] = r[7:0] + 8'h60;
            end
            fout.af = lo;
            fout.cf = hi;
        end
        OP_PADDW: begin
            lane_op = 1'b1;
            for (int i = 0; i < 4; i++) begin
                res[16*i +: 16] = a[16*i +: 16] + b[16*i +: 16];
            end
        end
        OP_PADDD: begin
            lane_op = 1'b1;
            res[31:0]  = a[31:0] + b[31:0];
            res[63:32] = a[63:32] + b[63:32];
        end
        OP_PACKSSWB: begin
            lane_op = 1'b1;
            for (int i = 0; i < 4; i++) begin
                res[8*i +: 8]      = sat_s8(a[16*i +: 16]);
                res[32 + 8*i +: 8] = sat_s8(b[16*i +: 16]);
            end
        end
        default: begin
            // high bytes interleaved, a on the even bytes
            lane_op = 1'b1;
            for (int i = 0; i < 4; i++) begin
                res[16*i +: 8]     = a[32 + 8*i +: 8];
                res[16*i + 8 +: 8] = b[32 + 8*i +: 8];
            end
        end
    endcase
    if (lane_op) begin
        wr = 1'b0;
    end else begin
        res = {32'd0, r};
        if (op == OP_BSF) begin
            fout.zf = (a[31:0] == 32'd0);
        end else begin
            fout.zf = (r == 32'd0);
            fout.sf = r[31];
            fout.pf = parity_even(r[7:0]);
        end
    end
    if (!wr) begin
        fout = fin;
    end
endfunction

`endif

// File: tb_exec_top.sv
module tb_exec_top;
    import alu_pkg::*;

    localparam int QUEUE_DEPTH   = 4;
    localparam int OUT_CREDITS   = 2;
    localparam int N_OPS         = 400;
    localparam int PERIOD        = 20;
    localparam int WITHHOLD_FROM = 300;
    localparam int WITHHOLD_TO   = 360;

    logic              clk;
    logic              rst_n;
    logic              in_valid;
    alu_op_e           in_op;
    logic [DATA_W-1:0] in_a;
    logic [DATA_W-1:0] in_b;
    logic              out_credit;
    logic              in_credit;
    logic              out_valid;
    logic [DATA_W-1:0] out_result;
    alu_flags_t        out_flags;
    logic              out_flags_valid;

    `include "tb_alu_model.svh"

    integer            seed = 51166;
    int                errors;
    int                cycle;
    int                sent;
    int                received;
    int                send_credits;
    int                in_credits_seen;
    int                out_credits_given;
    int                zero_shifts;
    logic [15:0]       ops_seen;
    logic              starved;
    alu_flags_t        model_flags;

    // scoreboard in send order
    alu_op_e           exp_op[$];
    logic [DATA_W-1:0] exp_res[$];
    alu_flags_t        exp_flags[$];
    logic              exp_fv[$];
    // cycle at which each pending output credit may go back
    int                ret_due[$];

    exec_top #(
        .QUEUE_DEPTH (QUEUE_DEPTH),
        .OUT_CREDITS (OUT_CREDITS)
    ) UUT (
        .clk             (clk),
        .rst_n           (rst_n),
        .in_valid        (in_valid),
        .in_op           (in_op),
        .in_a            (in_a),
        .in_b            (in_b),
        .out_credit      (out_credit),
        .in_credit       (in_credit),
        .out_valid       (out_valid),
        .out_result      (out_result),
        .out_flags       (out_flags),
        .out_flags_valid (out_flags_valid)
    );

    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(N_OPS * 20 * PERIOD);
        $display("watchdog expired with %0d of %0d results received", received, N_OPS);
        $display("FAIL: see errors above");
        $finish;
    end

    //////////////////////////////
    // checks
    //////////////////////////////

    task automatic compare_value(input string name, input logic [63:0] expected,
                                 input logic [63:0] actual);
        assert (expected === actual) else begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_rule(input logic ok, input string what);
        assert (ok) else begin
            errors++;
            $display("Error: %s", what);
        end
    endtask

    task automatic check_output();
        alu_op_e           op;
        string             name;
        logic [DATA_W-1:0] e_res;
        alu_flags_t        e_flags;
        logic              e_fv;
        if (exp_res.size() == 0) begin
            check_rule(1'b0, "out_valid with no operation outstanding");
        end else begin
            op      = exp_op.pop_front();
            e_res   = exp_res.pop_front();
            e_flags = exp_flags.pop_front();
            e_fv    = exp_fv.pop_front();
            name    = op.name();
            compare_value({name, " result"}, e_res, out_result);
            compare_value({name, " flags_valid"}, {63'd0, e_fv}, {63'd0, out_flags_valid});
            compare_value({name, " flags"}, {58'd0, e_flags}, {58'd0, out_flags});
        end
        received++;
    endtask

    //////////////////////////////
    // sender and receiver
    //////////////////////////////

    task automatic send_random();
        alu_op_e           op;
        logic [DATA_W-1:0] a;
        logic [DATA_W-1:0] b;
        logic [DATA_W-1:0] res;
        alu_flags_t        fl;
        logic              wr;
        op       = alu_op_e'($unsigned($random(seed)) % 13);
        a[63:32] = $random(seed);
        a[31:0]  = $random(seed);
        b[63:32] = $random(seed);
        b[31:0]  = $random(seed);
        // zero count now and then, flags must survive it
        if ((op == OP_SAL || op == OP_SAR) && ($unsigned($random(seed)) % 4 == 0)) begin
            b[4:0] = 5'd0;
            zero_shifts++;
        end
        model_op(op, a, b, model_flags, res, fl, wr);
        model_flags = fl;
        exp_op.push_back(op);
        exp_res.push_back(res);
        exp_flags.push_back(fl);
        exp_fv.push_back(wr);
        ops_seen[int'(op)] = 1'b1;
        in_valid <= 1'b1;
        in_op    <= op;
        in_a     <= a;
        in_b     <= b;
        sent++;
        send_credits--;
    endtask

    // one credit per pulse, none while held back
    task automatic return_credit(input logic withhold);
        out_credit <= 1'b0;
        if (!withhold && ret_due.size() > 0 && ret_due[0] <= cycle) begin
            void'(ret_due.pop_front());
            out_credit <= 1'b1;
            out_credits_given++;
        end
    endtask

    task automatic run_cycle();
        logic withhold;
        withhold = (cycle >= WITHHOLD_FROM) && (cycle < WITHHOLD_TO);
        // a pop frees the queue slot and shows its result in the same cycle
        check_rule(in_credit === out_valid, "in_credit and out_valid out of step");
        if (in_credit) begin
            in_credits_seen++;
            send_credits++;
        end
        if (out_valid) begin
            check_output();
            ret_due.push_back(cycle + int'($unsigned($random(seed)) % 4));
            check_rule(received - out_credits_given <= OUT_CREDITS,
                       "out_valid issued beyond the output credit");
        end
        return_credit(withhold);
        in_valid <= 1'b0;
        if (sent < N_OPS && send_credits > 0 && $unsigned($random(seed)) % 4 != 0) begin
            send_random();
        end
        if (withhold && send_credits == 0) begin
            starved = 1'b1;
        end
        cycle++;
    endtask

    //////////////////////////////
    // main sequence
    //////////////////////////////

    initial begin
        rst_n             = 1'b0;
        in_valid          = 1'b0;
        in_op             = OP_ADD;
        in_a              = '0;
        in_b              = '0;
        out_credit        = 1'b0;
        errors            = 0;
        cycle             = 0;
        sent              = 0;
        received          = 0;
        send_credits      = QUEUE_DEPTH;
        in_credits_seen   = 0;
        out_credits_given = 0;
        zero_shifts       = 0;
        ops_seen          = '0;
        starved           = 1'b0;
        model_flags       = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        // nothing sent yet, both handshakes quiet
        repeat (4) begin
            @(posedge clk);
            check_rule(!out_valid && !in_credit, "handshake active before the first send");
        end
        while (received < N_OPS) begin
            @(posedge clk);
            run_cycle();
        end
        check_rule(in_credits_seen == sent, "in_credit pulses differ from operations sent");
        check_rule(exp_res.size() == 0, "operations left in the scoreboard");
        check_rule(&ops_seen[12:0], "not every opcode was sent");
        check_rule(zero_shifts > 0, "no shift with a zero count was sent");
        check_rule(starved, "sender never ran out of credit while the receiver held back");
        $display("errors: %0d, sent: %0d, checked: %0d", errors, sent, received);
        if (errors == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
